/* access_guard_top.f */
rtl/access_guard_pkg.sv
rtl/guard_csr_port.sv
rtl/pmp_checker.sv
rtl/access_gate.sv
rtl/access_guard_top.sv
bench/tb_access_guard.sv

/* Makefile */
# Verilator build and run for the bus access guard

TOP := tb_access_guard
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f access_guard_top.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_access_guard.sv */
// bus access guard testbench
`timescale 1ns/1ps
`default_nettype none

module tb_access_guard;

	import access_guard_pkg::*;

	// about 60 cpu and host transactions of under 10 cycles each, plus reset
	localparam int MAX_CYCLES = 4000;
	localparam logic [31:0] DEV_KEY = 32'h5a5a_0f0f;

	logic  clk;
	logic  rst;
	tl_a_t host_a_i;
	logic  host_a_ready_o;
	tl_d_t host_d_o;
	logic  host_d_ready_i;
	tl_a_t dev_a_o;
	logic  dev_a_ready_i;
	tl_d_t dev_d_i = '0;
	logic  dev_d_ready_o;
	tl_a_t cpu_a_i;
	logic  cpu_a_ready_o;
	tl_d_t cpu_d_o;
	logic  cpu_d_ready_i;
	logic  irq_o;

	// expectations set by the stimulus for the concurrent checks
	bit exp_permit;
	bit exp_block;
	int assert_errs;
	int value_errs;
	int cycles;

	// device model state
	bit    dev_pend = 1'b0;
	tl_d_t dev_rsp;

	access_guard_top #(
		.NumRegions(4)
	) DUT (
		.clk           (clk),
		.rst           (rst),
		.host_a_i      (host_a_i),
		.host_a_ready_o(host_a_ready_o),
		.host_d_o      (host_d_o),
		.host_d_ready_i(host_d_ready_i),
		.dev_a_o       (dev_a_o),
		.dev_a_ready_i (dev_a_ready_i),
		.dev_d_i       (dev_d_i),
		.dev_d_ready_o (dev_d_ready_o),
		.cpu_a_i       (cpu_a_i),
		.cpu_a_ready_o (cpu_a_ready_o),
		.cpu_d_o       (cpu_d_o),
		.cpu_d_ready_i (cpu_d_ready_i),
		.irq_o         (irq_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// device takes every request and answers one cycle later
	always @(posedge clk) begin
		if (dev_d_i.d_valid && dev_d_ready_o) begin
			dev_pend <= 1'b0;
		end
		if (dev_a_o.a_valid && dev_a_ready_i) begin
			dev_pend         <= 1'b1;
			dev_rsp.d_valid  <= 1'b1;
			dev_rsp.d_opcode <= (dev_a_o.a_opcode == Get) ? AccessAckData : AccessAck;
			dev_rsp.d_data   <= dev_a_o.a_address ^ DEV_KEY;
			dev_rsp.d_source <= dev_a_o.a_source;
			dev_rsp.d_error  <= 1'b0;
		end
	end

	always @(negedge clk) begin
		dev_d_i = dev_pend ? dev_rsp : '0;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// permitted request reaches the device unchanged in the same cycle
	a_forward: assert property (@(posedge clk) disable iff (!rst)
		exp_permit && host_a_i.a_valid |-> dev_a_o.a_valid && dev_a_o == host_a_i)
	else begin
		assert_errs++;
		$display("ERROR %0t dev_a_o expected %h got %h", $time, host_a_i, dev_a_o);
	end

	// refused or blocked request never reaches the device
	a_no_forward: assert property (@(posedge clk) disable iff (!rst)
		exp_block |-> !dev_a_o.a_valid)
	else begin
		assert_errs++;
		$display("ERROR %0t dev_a_o.a_valid expected 0 got %b", $time, dev_a_o.a_valid);
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			value_errs++;
			$display("ERROR %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// one cpu transaction, returns data and error flag
	task automatic cpu_access(input tl_op_e op, input logic [7:0] idx, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(negedge clk);
		cpu_a_i.a_valid   = 1'b1;
		cpu_a_i.a_opcode  = op;
		cpu_a_i.a_address = {22'b0, idx, 2'b00};
		cpu_a_i.a_data    = wdata;
		cpu_a_i.a_source  = 8'h3c;
		#1;
		while (!cpu_a_ready_o) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		cpu_a_i.a_valid = 1'b0;
		#1;
		while (!cpu_d_o.d_valid) begin
			@(negedge clk);
			#1;
		end
		// an outstanding response blocks new requests
		check_val("cpu_a_ready_o", 0, cpu_a_ready_o);
		check_val("cpu_d_o.d_source", 32'h3c, cpu_d_o.d_source);
		check_val("cpu_d_o.d_opcode", (op == Get) ? AccessAckData : AccessAck, cpu_d_o.d_opcode);
		rdata = cpu_d_o.d_data;
		err   = cpu_d_o.d_error;
	endtask

	task automatic cpu_write(input logic [7:0] idx, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		cpu_access(PutFullData, idx, data, rd, err);
		check_val("cpu_d_o.d_error", 0, err);
	endtask

	task automatic cpu_read(input logic [7:0] idx, output logic [31:0] data);
		logic err;
		cpu_access(Get, idx, 32'h0, data, err);
		check_val("cpu_d_o.d_error", 0, err);
	endtask

	task automatic cpu_expect_error(input tl_op_e op, input logic [7:0] idx);
		logic [31:0] rd;
		logic        err;
		cpu_access(op, idx, 32'hdead_beef, rd, err);
		check_val("cpu_d_o.d_error", 1, err);
	endtask

	// one host transaction, checks the response against the device or error rule
	task automatic host_access(input tl_op_e op, input logic [31:0] addr, input logic [7:0] src,
			input bit refused);
		@(negedge clk);
		host_a_i.a_valid   = 1'b1;
		host_a_i.a_opcode  = op;
		host_a_i.a_address = addr;
		host_a_i.a_data    = $urandom;
		host_a_i.a_source  = src;
		exp_permit         = !refused;
		exp_block          = refused;
		#1;
		while (!host_a_ready_o) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		@(negedge clk);
		host_a_i.a_valid = 1'b0;
		exp_permit       = 1'b0;
		#1;
		while (!host_d_o.d_valid) begin
			@(negedge clk);
			#1;
		end
		// device side ready follows the host only while the path is open
		check_val("dev_d_ready_o", refused ? 1'b0 : host_d_ready_i, dev_d_ready_o);
		check_val("host_d_o.d_error", refused, host_d_o.d_error);
		check_val("host_d_o.d_source", src, host_d_o.d_source);
		check_val("host_d_o.d_opcode", (op == Get) ? AccessAckData : AccessAck, host_d_o.d_opcode);
		check_val("host_d_o.d_data", refused ? 32'h0 : (addr ^ DEV_KEY), host_d_o.d_data);
	endtask

	// host keeps asking while the guard is locked
	task automatic check_blocked();
		@(negedge clk);
		host_a_i.a_valid   = 1'b1;
		host_a_i.a_opcode  = Get;
		host_a_i.a_address = 32'h0000_1000;
		exp_block          = 1'b1;
		repeat (3) begin
			#1;
			check_val("host_a_ready_o", 0, host_a_ready_o);
			@(negedge clk);
		end
		host_a_i.a_valid = 1'b0;
	endtask

	// refused request, denial record, lock and release
	task automatic deny_and_release(input tl_op_e op, input logic [31:0] addr,
			input logic [7:0] src);
		logic [31:0] rd;
		host_access(op, addr, src, 1'b1);
		cpu_read(DENIED_ADDR_IDX, rd);
		check_val("denied address", addr, rd);
		cpu_read(DENIED_TYPE_IDX, rd);
		check_val("denied type", op, rd);
		cpu_read(STATE_IDX, rd);
		check_val("guard state", LOCKED, rd);
		check_blocked();
		cpu_write(RELEASE_IDX, 32'h1);
		cpu_read(STATE_IDX, rd);
		check_val("guard state", OPEN, rd);
		exp_block = 1'b0;
	endtask

	initial begin
		logic [31:0] wd;
		logic [31:0] rd;
		logic [31:0] addr;
		int          pick;

		void'($urandom(32'hfff1_fcc6));
		rst            = 1'b0;
		host_a_i       = '0;
		host_d_ready_i = 1'b1;
		dev_a_ready_i  = 1'b1;
		cpu_a_i        = '0;
		cpu_d_ready_i  = 1'b1;
		exp_permit     = 1'b0;
		exp_block      = 1'b0;
		assert_errs    = 0;
		value_errs     = 0;
		cycles         = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// region table words read back as written, config word 0 and address words 1 to 4
		for (int i = 0; i < 5; i++) begin
			wd = $urandom;
			cpu_write(8'(i), wd);
			cpu_read(8'(i), rd);
			check_val("region word", wd, rd);
		end
		cpu_expect_error(Get, 8'd100);
		cpu_read(8'd1, wd);
		cpu_expect_error(PutPartialData, 8'd1);
		cpu_read(8'd1, rd);
		check_val("region word after partial write", wd, rd);

		// region 1 TOR rw over 0x1000..0x1fff, region 2 NA4 read only at 0x3000
		cpu_write(8'd0, 32'h0011_0b00);
		cpu_write(8'd1, 32'h0000_0400);
		cpu_write(8'd2, 32'h0000_0800);
		cpu_write(8'd3, 32'h0000_0c00);
		cpu_write(8'd4, 32'h0000_0000);
		cpu_write(INTR_ENABLE_IDX, 32'h8000_0000);

		// permitted traffic
		for (int i = 0; i < 20; i++) begin
			pick = $urandom % 3;
			addr = 32'h0000_1000 + (($urandom % 1024) << 2);
			case (pick)
				0:       host_access(Get, addr, 8'($urandom), 1'b0);
				1:       host_access(PutFullData, addr, 8'($urandom), 1'b0);
				default: host_access(Get, 32'h0000_3000, 8'($urandom), 1'b0);
			endcase
		end

		// write to the read only word, interrupt enabled
		deny_and_release(PutFullData, 32'h0000_3000, 8'h21);
		check_val("irq_o", 1, irq_o);
		cpu_write(INTR_STATE_IDX, 32'h0);
		#1;
		check_val("irq_o", 0, irq_o);
		host_access(Get, 32'h0000_1ffc, 8'h22, 1'b0);

		// access outside every region, interrupt masked
		cpu_write(INTR_ENABLE_IDX, 32'h0);
		deny_and_release(Get, 32'h0000_5000, 8'h23);
		check_val("irq_o", 0, irq_o);
		cpu_read(INTR_STATE_IDX, rd);
		check_val("interrupt state", 1, rd[31]);
		cpu_write(INTR_STATE_IDX, 32'h0);

		// release while the error response is still held
		@(negedge clk);
		host_d_ready_i = 1'b0;
		host_access(Get, 32'h0000_5004, 8'h24, 1'b1);
		cpu_write(RELEASE_IDX, 32'h1);
		cpu_read(STATE_IDX, rd);
		check_val("guard state", RSP_PENDING, rd);
		#1;
		check_val("host_d_o.d_valid", 1, host_d_o.d_valid);
		@(negedge clk);
		host_d_ready_i = 1'b1;
		@(negedge clk);
		exp_block = 1'b0;
		cpu_read(STATE_IDX, rd);
		check_val("guard state", OPEN, rd);
		host_access(PutFullData, 32'h0000_1800, 8'h25, 1'b0);

		repeat (4) @(negedge clk);
		$display("errors: %0d assertion, %0d value", assert_errs, value_errs);
		if (assert_errs == 0 && value_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/access_guard_top.sv */
// bus access guard top
`timescale 1ns/1ps
`default_nettype none

module access_guard_top #(
	parameter int NumRegions = 4
) (
	input  wire logic                    clk,
	input  wire logic                    rst,
	// untrusted host
	input  wire access_guard_pkg::tl_a_t host_a_i,
	output logic                         host_a_ready_o,
	output access_guard_pkg::tl_d_t      host_d_o,
	input  wire logic                    host_d_ready_i,
	// protected device
	output access_guard_pkg::tl_a_t      dev_a_o,
	input  wire logic                    dev_a_ready_i,
	input  wire access_guard_pkg::tl_d_t dev_d_i,
	output logic                         dev_d_ready_o,
	// cpu register port
	input  wire access_guard_pkg::tl_a_t cpu_a_i,
	output logic                         cpu_a_ready_o,
	output access_guard_pkg::tl_d_t      cpu_d_o,
	input  wire logic                    cpu_d_ready_i,
	output logic                         irq_o
);

	import access_guard_pkg::*;

	pmp_cfg_t    pmp_cfg [NumRegions];
	logic [31:0] pmp_addr [NumRegions];
	logic        release_pulse;
	logic [31:0] host_addr;
	logic        host_is_read;
	logic        deny;
	logic        deny_pulse;
	denial_t     denial;
	gate_state_e gate_state;

	// cpu side registers and region table
	guard_csr_port #(
		.NumRegions(NumRegions)
	) u_csr (
		.clk          (clk),
		.rst          (rst),
		.cpu_a_i      (cpu_a_i),
		.cpu_d_ready_i(cpu_d_ready_i),
		.cpu_a_ready_o(cpu_a_ready_o),
		.cpu_d_o      (cpu_d_o),
		.deny_pulse_i (deny_pulse),
		.denial_i     (denial),
		.gate_state_i (gate_state),
		.pmp_cfg_o    (pmp_cfg),
		.pmp_addr_o   (pmp_addr),
		.release_o    (release_pulse),
		.irq_o        (irq_o)
	);

	// permission check of the current host request
	pmp_checker #(
		.NumRegions(NumRegions)
	) u_pmp (
		.cfg_i        (pmp_cfg),
		.addr_i       (pmp_addr),
		.req_addr_i   (host_addr),
		.req_is_read_i(host_is_read),
		.deny_o       (deny)
	);

	// host to device path
	access_gate u_gate (
		.clk           (clk),
		.rst           (rst),
		.host_a_i      (host_a_i),
		.host_a_ready_o(host_a_ready_o),
		.host_d_o      (host_d_o),
		.host_d_ready_i(host_d_ready_i),
		.dev_a_o       (dev_a_o),
		.dev_a_ready_i (dev_a_ready_i),
		.dev_d_i       (dev_d_i),
		.dev_d_ready_o (dev_d_ready_o),
		.req_addr_o    (host_addr),
		.req_is_read_o (host_is_read),
		.deny_i        (deny),
		.release_i     (release_pulse),
		.deny_pulse_o  (deny_pulse),
		.denial_o      (denial),
		.state_o       (gate_state)
	);

endmodule

`default_nettype wire

/* rtl/access_gate.sv */
// host access gate fsm
`timescale 1ns/1ps
`default_nettype none

module access_gate (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire access_guard_pkg::tl_a_t host_a_i,
	output logic                         host_a_ready_o,
	output access_guard_pkg::tl_d_t      host_d_o,
	input  wire logic                    host_d_ready_i,
	output access_guard_pkg::tl_a_t      dev_a_o,
	input  wire logic                    dev_a_ready_i,
	input  wire access_guard_pkg::tl_d_t dev_d_i,
	output logic                         dev_d_ready_o,
	output logic [31:0]                  req_addr_o,
	output logic                         req_is_read_o,
	input  wire logic                    deny_i,
	input  wire logic                    release_i,
	output logic                         deny_pulse_o,
	output access_guard_pkg::denial_t    denial_o,
	output access_guard_pkg::gate_state_e state_o
);

	import access_guard_pkg::*;

	gate_state_e state_q;
	gate_state_e state_d;
	denial_t     denial_q;
	logic [7:0]  src_q;
	tl_rsp_op_e  rsp_op_q;
	tl_d_t       err_rsp;

	// checker looks at the live host request
	assign req_addr_o    = host_a_i.a_address;
	assign req_is_read_o = (host_a_i.a_opcode == Get);

	// refused request is taken from the host but never forwarded
	assign deny_pulse_o = (state_q == OPEN) && host_a_i.a_valid && dev_a_ready_i && deny_i;

	// error response built from the captured request
	assign err_rsp.d_valid  = 1'b1;
	assign err_rsp.d_opcode = rsp_op_q;
	assign err_rsp.d_data   = '0;
	assign err_rsp.d_source = src_q;
	assign err_rsp.d_error  = 1'b1;

	always_comb begin
		state_d = state_q;
		case (state_q)
			OPEN: begin
				if (deny_pulse_o) begin
					state_d = DENY_RSP;
				end
			end
			DENY_RSP: begin
				// release may come before the host takes the error
				if (host_d_ready_i && release_i) begin
					state_d = OPEN;
				end else if (host_d_ready_i) begin
					state_d = LOCKED;
				end else if (release_i) begin
					state_d = RSP_PENDING;
				end
			end
			RSP_PENDING: begin
				if (host_d_ready_i) begin
					state_d = OPEN;
				end
			end
			default: begin
				if (release_i) begin
					state_d = OPEN;
				end
			end
		endcase
	end

	// channel steering
	always_comb begin
		dev_a_o         = host_a_i;
		dev_a_o.a_valid = 1'b0;
		host_a_ready_o  = 1'b0;
		dev_d_ready_o   = 1'b0;
		host_d_o        = err_rsp;
		case (state_q)
			OPEN: begin
				// straight pass through, no added latency
				dev_a_o.a_valid = host_a_i.a_valid && !deny_i;
				host_a_ready_o  = dev_a_ready_i;
				dev_d_ready_o   = host_d_ready_i;
				host_d_o        = dev_d_i;
			end
			DENY_RSP, RSP_PENDING: host_d_o = err_rsp;
			// locked, nothing goes back to the host
			default: host_d_o.d_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q  <= OPEN;
			denial_q <= '0;
		end else begin
			state_q <= state_d;
			if (deny_pulse_o) begin
				denial_q.address <= host_a_i.a_address;
				denial_q.opcode  <= host_a_i.a_opcode;
			end
		end
	end

	// error response payload
	always_ff @(posedge clk) begin
		if (deny_pulse_o) begin
			src_q    <= host_a_i.a_source;
			rsp_op_q <= (host_a_i.a_opcode == Get) ? AccessAckData : AccessAck;
		end
	end

	assign denial_o = denial_q;
	assign state_o  = state_q;

	// no request reaches the device while the path is blocked
	a_no_fwd_blocked: assert property (@(posedge clk) disable iff (!rst)
		state_q != OPEN |-> !dev_a_o.a_valid);

endmodule

`default_nettype wire

/* rtl/pmp_checker.sv */
// pmp region checker
`timescale 1ns/1ps
`default_nettype none

module pmp_checker #(
	parameter int NumRegions = 4
) (
	input  wire access_guard_pkg::pmp_cfg_t cfg_i [NumRegions],
	input  wire logic [31:0]                addr_i [NumRegions],
	input  wire logic [31:0]                req_addr_i,
	input  wire logic                       req_is_read_i,
	output logic                            deny_o
);

	import access_guard_pkg::*;

	logic [31:0]           req_word;
	logic [NumRegions-1:0] match;
	logic [NumRegions-1:0] allow;

	// table entries hold byte address >> 2
	assign req_word = {2'b00, req_addr_i[31:2]};

	for (genvar k = 0; k < NumRegions; k++) begin : g_region
		logic [31:0] lower;

		// TOR bottom is the previous entry, zero for the first one
		if (k == 0) begin : g_first
			assign lower = '0;
		end else begin : g_next
			assign lower = addr_i[k - 1];
		end

		always_comb begin
			case (cfg_i[k].mode)
				TOR:     match[k] = (lower <= req_word) && (req_word < addr_i[k]);
				NA4:     match[k] = (req_word == addr_i[k]);
				// OFF and the unused encoding
				default: match[k] = 1'b0;
			endcase
		end

		// everything that is not a read needs write permission
		assign allow[k] = req_is_read_i ? cfg_i[k].read : cfg_i[k].write;
	end

	// walk from the top so the lowest matching region has the last word
	always_comb begin
		deny_o = 1'b1;
		for (int k = NumRegions - 1; k >= 0; k--) begin
			if (match[k]) begin
				deny_o = !allow[k];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/guard_csr_port.sv */
// guard cpu register port
`timescale 1ns/1ps
`default_nettype none

module guard_csr_port #(
	parameter int NumRegions = 4
) (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire access_guard_pkg::tl_a_t       cpu_a_i,
	input  wire logic                          cpu_d_ready_i,
	output logic                               cpu_a_ready_o,
	output access_guard_pkg::tl_d_t            cpu_d_o,
	input  wire logic                          deny_pulse_i,
	input  wire access_guard_pkg::denial_t     denial_i,
	input  wire access_guard_pkg::gate_state_e gate_state_i,
	output access_guard_pkg::pmp_cfg_t         pmp_cfg_o [NumRegions],
	output logic [31:0]                        pmp_addr_o [NumRegions],
	output logic                               release_o,
	output logic                               irq_o
);

	import access_guard_pkg::*;

	// four config bytes per word, address words follow the config words
	localparam int NumCfgWords = NumRegions / 4;
	localparam int AddrBase    = NumCfgWords;
	localparam int IdxW        = $clog2(CSR_WORDS);

	logic [31:0]         cfg_words  [NumCfgWords];
	logic [31:0]         addr_words [NumRegions];
	logic [IdxW-1:0]     word_idx;
	logic                accept;
	logic [NumCfgWords-1:0] cfg_hit;
	logic [NumRegions-1:0]  addr_hit;
	logic [NumCfgWords-1:0] wr_cfg;
	logic [NumRegions-1:0]  wr_addr;
	logic                wr_release;
	logic                wr_intr_clr;
	logic                wr_intr_en;
	logic                rsp_err;
	logic [31:0]         rsp_data;
	tl_rsp_op_e          rsp_op;
	tl_d_t               cpu_d_q;
	logic                intr_state_q;
	logic                intr_enable_q;

	// only one response in flight
	assign cpu_a_ready_o = !cpu_d_q.d_valid;
	assign accept        = cpu_a_i.a_valid && cpu_a_ready_o;
	assign word_idx      = cpu_a_i.a_address[9:2];

	// one-hot hits on the region table words
	always_comb begin
		for (int k = 0; k < NumCfgWords; k++) begin
			cfg_hit[k] = (int'(word_idx) == k);
		end
		for (int k = 0; k < NumRegions; k++) begin
			addr_hit[k] = (int'(word_idx) == AddrBase + k);
		end
	end

	// request decode, error leaves all state untouched
	always_comb begin
		wr_cfg      = '0;
		wr_addr     = '0;
		wr_release  = 1'b0;
		wr_intr_clr = 1'b0;
		wr_intr_en  = 1'b0;
		rsp_err     = 1'b0;
		rsp_data    = '0;
		rsp_op      = AccessAck;
		case (cpu_a_i.a_opcode)
			PutFullData: begin
				if (|cfg_hit) begin
					wr_cfg = cfg_hit;
				end else if (|addr_hit) begin
					wr_addr = addr_hit;
				end else begin
					case (word_idx)
						RELEASE_IDX:     wr_release  = 1'b1;
						INTR_STATE_IDX:  wr_intr_clr = 1'b1;
						INTR_ENABLE_IDX: wr_intr_en  = 1'b1;
						default:         rsp_err     = 1'b1;
					endcase
				end
			end
			Get: begin
				rsp_op = AccessAckData;
				for (int k = 0; k < NumCfgWords; k++) begin
					if (cfg_hit[k]) begin
						rsp_data = cfg_words[k];
					end
				end
				for (int k = 0; k < NumRegions; k++) begin
					if (addr_hit[k]) begin
						rsp_data = addr_words[k];
					end
				end
				if (!(|cfg_hit) && !(|addr_hit)) begin
					case (word_idx)
						DENIED_ADDR_IDX: rsp_data      = denial_i.address;
						DENIED_TYPE_IDX: rsp_data[2:0] = denial_i.opcode;
						STATE_IDX:       rsp_data[1:0] = gate_state_i;
						INTR_STATE_IDX:  rsp_data[31]  = intr_state_q;
						INTR_ENABLE_IDX: rsp_data[31]  = intr_enable_q;
						default:         rsp_err       = 1'b1;
					endcase
				end
			end
			// partial writes and unknown opcodes are refused
			default: rsp_err = 1'b1;
		endcase
	end

	// region table
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg_words  <= '{default: '0};
			addr_words <= '{default: '0};
		end else if (accept) begin
			for (int k = 0; k < NumCfgWords; k++) begin
				if (wr_cfg[k]) begin
					cfg_words[k] <= cpu_a_i.a_data;
				end
			end
			for (int k = 0; k < NumRegions; k++) begin
				if (wr_addr[k]) begin
					addr_words[k] <= cpu_a_i.a_data;
				end
			end
		end
	end

	// response register, release pulse and interrupt bits
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cpu_d_q       <= '0;
			release_o     <= 1'b0;
			intr_state_q  <= 1'b0;
			intr_enable_q <= 1'b0;
		end else begin
			release_o <= accept && wr_release;
			if (accept) begin
				cpu_d_q.d_valid  <= 1'b1;
				cpu_d_q.d_opcode <= rsp_op;
				cpu_d_q.d_data   <= rsp_data;
				cpu_d_q.d_source <= cpu_a_i.a_source;
				cpu_d_q.d_error  <= rsp_err;
			end else if (cpu_d_ready_i) begin
				cpu_d_q.d_valid <= 1'b0;
			end
			// a new denial wins over a clear in the same cycle
			if (deny_pulse_i) begin
				intr_state_q <= 1'b1;
			end else if (accept && wr_intr_clr) begin
				intr_state_q <= 1'b0;
			end
			if (accept && wr_intr_en) begin
				intr_enable_q <= cpu_a_i.a_data[31];
			end
		end
	end

	// config bytes unpacked per region
	for (genvar k = 0; k < NumRegions; k++) begin : g_cfg_out
		assign pmp_cfg_o[k]  = pmp_cfg_t'(cfg_words[k / 4][8 * (k % 4) +: 8]);
		assign pmp_addr_o[k] = addr_words[k];
	end

	assign cpu_d_o = cpu_d_q;
	assign irq_o   = intr_state_q & intr_enable_q;

	// a pending response holds until the cpu takes it
	a_cpu_rsp_hold: assert property (@(posedge clk) disable iff (!rst)
		cpu_d_o.d_valid && !cpu_d_ready_i |=> cpu_d_o.d_valid && $stable(cpu_d_o));

endmodule

`default_nettype wire

/* rtl/access_guard_pkg.sv */
// bus access guard shared types
`default_nettype none

package access_guard_pkg;

	// request opcodes, TL-UL A channel encoding
	typedef enum logic [2:0] {
		PutFullData    = 3'd0,
		PutPartialData = 3'd1,
		Get            = 3'd4
	} tl_op_e;

	// response opcodes, TL-UL D channel encoding
	typedef enum logic [2:0] {
		AccessAck     = 3'd0,
		AccessAckData = 3'd1
	} tl_rsp_op_e;

	// request channel, ready travels on its own wire
	typedef struct packed {
		logic        a_valid;
		tl_op_e      a_opcode;
		logic [31:0] a_address;
		logic [31:0] a_data;
		logic [7:0]  a_source;
	} tl_a_t;

	// response channel
	typedef struct packed {
		logic        d_valid;
		tl_rsp_op_e  d_opcode;
		logic [31:0] d_data;
		logic [7:0]  d_source;
		logic        d_error;
	} tl_d_t;

	// region match mode, encoding 3 behaves like OFF
	typedef enum logic [1:0] {
		OFF = 2'd0,
		TOR = 2'd1,
		NA4 = 2'd2
	} pmp_mode_e;

	// one config byte per region
	typedef struct packed {
		logic [2:0] rsvd_hi;
		pmp_mode_e  mode;
		logic       rsvd_lo;
		logic       write;
		logic       read;
	} pmp_cfg_t;

	// guard state as seen by the cpu
	typedef enum logic [1:0] {
		OPEN        = 2'd0,
		DENY_RSP    = 2'd1,
		RSP_PENDING = 2'd2,
		LOCKED      = 2'd3
	} gate_state_e;

	// last refused host request
	typedef struct packed {
		logic [31:0] address;
		tl_op_e      opcode;
	} denial_t;

	// cpu register map, word index = address bits 9:2
	localparam logic [7:0] RELEASE_IDX     = 8'd240;
	localparam logic [7:0] DENIED_ADDR_IDX = 8'd241;
	localparam logic [7:0] DENIED_TYPE_IDX = 8'd242;
	localparam logic [7:0] STATE_IDX       = 8'd243;
	localparam logic [7:0] INTR_STATE_IDX  = 8'd244;
	localparam logic [7:0] INTR_ENABLE_IDX = 8'd245;
	localparam int unsigned CSR_WORDS      = 256;

endpackage

`default_nettype wire
